// File: sprite_pkg.sv
package sprite_pkg;

    // command codes, first byte of every SPI command
    localparam logic [7:0] command_save_sprite = 8'h01;
    localparam logic [7:0] command_draw_sprite = 8'h02;

    // bytes that follow each command byte
    localparam logic [15:0] save_data_count = 16'd513; // id + 256 pixels of 2 bytes
    localparam logic [15:0] draw_data_count = 16'd6;   // id, x hi/lo, y hi/lo, flags

    // sprite geometry
    localparam int sprite_side = 16;
    localparam int sprite_words = sprite_side * sprite_side;

    typedef logic [15:0] pixel_t; // 16-bit color
    typedef logic [15:0] coord_t; // screen position, wraps at 16 bits

endpackage

// File: spi_byte_reader.sv
`timescale 1ns/1ps

module spi_byte_reader (
    input  logic       clock,
    input  logic       reset,
    input  logic       cs,        // active low select
    input  logic       sck,
    input  logic       mosi,
    output logic       byte_read, // one-cycle pulse per completed byte
    output logic [7:0] data       // last completed byte
);

    logic [1:0] sck_sync;    // [0] first stage, [1] second stage
    logic       mosi_sync;   // aligned with sck_sync[0]
    logic       sck_rise;
    logic [2:0] bit_count;
    logic [7:0] read_buffer;

    assign sck_rise = sck_sync[0] & ~sck_sync[1];

    // sck and mosi come from another clock domain
    always_ff @(posedge clock) begin
        sck_sync  <= {sck_sync[0], sck};
        mosi_sync <= mosi;
    end

    always_ff @(posedge clock) begin
        if (reset || cs) begin
            bit_count <= '0;
            byte_read <= 1'b0;
        end else begin
            byte_read <= 1'b0;
            if (sck_rise) begin
                bit_count <= bit_count + 3'd1; // wraps to 0 after the eighth bit
                if (bit_count == 3'd7) begin
                    byte_read <= 1'b1;
                end
            end
        end
    end

    // shift register and output byte carry no reset
    always_ff @(posedge clock) begin
        if (sck_rise) begin
            read_buffer <= {read_buffer[6:0], mosi_sync};
            if (bit_count == 3'd7) begin
                data <= {read_buffer[6:0], mosi_sync};
            end
        end
    end

endmodule

// File: spi_command_parser.sv
`timescale 1ns/1ps

module spi_command_parser import sprite_pkg::*; #(
    parameter int sprite_count = 8
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       cs,
    input  logic       byte_read,
    input  logic [7:0] data,
    output logic       sprite_byte_valid,
    output logic [7:0] sprite_id,
    output logic [8:0] byte_offset,      // 0 to 511 within the sprite
    output logic [7:0] sprite_data,
    output logic       draw_valid,
    output logic [7:0] draw_id,
    output coord_t     draw_x,
    output coord_t     draw_y,
    output logic [7:0] draw_flags
);

    logic [7:0]  command;
    logic [15:0] data_count; // bytes expected after the command
    logic [15:0] data_index; // bytes received after the command

    always_ff @(posedge clock) begin
        if (reset || cs) begin
            command           <= '0;
            data_count        <= '0;
            data_index        <= '0;
            sprite_byte_valid <= 1'b0;
            draw_valid        <= 1'b0;
        end else begin
            sprite_byte_valid <= 1'b0;
            draw_valid        <= 1'b0;
            if (byte_read) begin
                if (data_index == data_count) begin
                    // previous command complete, this byte is a new command
                    command    <= data;
                    data_index <= '0;
                    case (data)
                        command_save_sprite: data_count <= save_data_count;
                        command_draw_sprite: data_count <= draw_data_count;
                        default:             data_count <= '0; // unknown, skip it
                    endcase
                end else begin
                    data_index <= data_index + 16'd1;
                    if (command == command_save_sprite && data_index != 16'd0) begin
                        sprite_byte_valid <= (sprite_id < sprite_count);
                    end
                    if (command == command_draw_sprite && data_index == 16'd5) begin
                        draw_valid <= (draw_id < sprite_count);
                    end
                end
            end
        end
    end

    // command fields, latched by position within the command
    always_ff @(posedge clock) begin
        if (byte_read && data_index != data_count) begin
            if (command == command_save_sprite) begin
                if (data_index == 16'd0) begin
                    sprite_id <= data;
                end else begin
                    byte_offset <= 9'(data_index - 16'd1);
                    sprite_data <= data;
                end
            end
            if (command == command_draw_sprite) begin
                case (data_index)
                    16'd0:   draw_id      <= data;
                    16'd1:   draw_x[15:8] <= data;
                    16'd2:   draw_x[7:0]  <= data;
                    16'd3:   draw_y[15:8] <= data;
                    16'd4:   draw_y[7:0]  <= data;
                    default: draw_flags   <= data;
                endcase
            end
        end
    end

endmodule

// File: sprite_loader.sv
`timescale 1ns/1ps

module sprite_loader import sprite_pkg::*; #(
    parameter int sprite_count = 8,
    localparam int address_width = $clog2(sprite_count * sprite_words)
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     sprite_byte_valid,
    input  logic [7:0]               sprite_id,
    input  logic [8:0]               byte_offset,
    input  logic [7:0]               sprite_data,
    output logic                     write_request,
    output logic [address_width-1:0] write_address,
    output pixel_t                   write_data
);

    logic [7:0] high_byte; // waits for its low byte partner

    always_ff @(posedge clock) begin
        if (reset) begin
            write_request <= 1'b0;
        end else begin
            write_request <= sprite_byte_valid & byte_offset[0];
        end
    end

    always_ff @(posedge clock) begin
        if (sprite_byte_valid) begin
            if (!byte_offset[0]) begin
                high_byte <= sprite_data; // even offset carries the high byte
            end else begin
                write_data    <= {high_byte, sprite_data};
                write_address <= address_width'(sprite_id * sprite_words + byte_offset[8:1]);
            end
        end
    end

endmodule

// File: sprite_ram_arbiter.sv
`timescale 1ns/1ps

module sprite_ram_arbiter import sprite_pkg::*; #(
    parameter int sprite_count = 8,
    localparam int address_width = $clog2(sprite_count * sprite_words)
) (
    input  logic                     write_request,
    input  logic [address_width-1:0] write_address,
    input  pixel_t                   write_data,
    input  logic                     read_request,
    input  logic [address_width-1:0] read_address,
    output logic                     read_grant,
    output logic                     ram_enable,
    output logic                     ram_write,
    output logic [address_width-1:0] ram_address,
    output pixel_t                   ram_write_data
);

    // loader writes never wait, the blitter reads in the gaps
    assign read_grant     = read_request & ~write_request;
    assign ram_enable     = write_request | read_request;
    assign ram_write      = write_request;
    assign ram_address    = write_request ? write_address : read_address;
    assign ram_write_data = write_data;

endmodule

// File: sprite_ram.sv
`timescale 1ns/1ps

module sprite_ram import sprite_pkg::*; #(
    parameter int sprite_count = 8,
    localparam int address_width = $clog2(sprite_count * sprite_words)
) (
    input  logic                     clock,
    input  logic                     ram_enable,
    input  logic                     ram_write,
    input  logic [address_width-1:0] ram_address,
    input  pixel_t                   ram_write_data,
    output pixel_t                   ram_read_data
);

    pixel_t memory [sprite_count * sprite_words]; // one 256-word block per sprite

    always_ff @(posedge clock) begin
        if (ram_enable) begin
            if (ram_write) begin
                memory[ram_address] <= ram_write_data;
            end
            ram_read_data <= memory[ram_address]; // old contents on a write
        end
    end

endmodule

// File: sprite_blitter.sv
`timescale 1ns/1ps

module sprite_blitter import sprite_pkg::*; #(
    parameter int sprite_count = 8,
    localparam int address_width = $clog2(sprite_count * sprite_words),
    localparam int index_width = $clog2(sprite_words),
    localparam int side_width = $clog2(sprite_side)
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     draw_valid,
    input  logic [7:0]               draw_id,
    input  coord_t                   draw_x,
    input  coord_t                   draw_y,
    input  logic [7:0]               draw_flags,
    output logic                     read_request,
    output logic [address_width-1:0] read_address,
    input  logic                     read_grant,
    input  pixel_t                   read_data,
    output logic                     pixel_valid,
    output coord_t                   pixel_x,
    output coord_t                   pixel_y,
    output pixel_t                   pixel_color,
    output logic                     draw_busy
);

    logic                   active;        // a draw owns the read port or the pipe
    logic                   reading;       // reads still to issue for the active draw
    logic [index_width-1:0] pixel_index;
    logic [7:0]             active_id;
    coord_t                 active_x;
    coord_t                 active_y;
    logic [7:0]             active_flags;
    logic                   pending_valid;
    logic [7:0]             pending_id;
    coord_t                 pending_x;
    coord_t                 pending_y;
    logic [7:0]             pending_flags;
    logic                   tag_valid;     // tag stage 1, aligned with read_data
    logic [side_width-1:0]  tag_column;
    logic [side_width-1:0]  tag_row;
    logic                   granted;
    logic                   finish;
    logic                   slot_free;
    logic                   take_pending;
    logic                   take_draw;
    logic                   store_pending;

    assign read_request = active & reading;
    assign read_address = address_width'(active_id * sprite_words + pixel_index);
    assign granted      = read_request & read_grant;

    // last read returned and its pixel is in the output stage
    assign finish       = active & ~reading & ~tag_valid;
    assign slot_free    = ~active | finish;
    assign take_pending = slot_free & pending_valid;
    assign take_draw    = slot_free & ~pending_valid & draw_valid;
    assign draw_busy    = active;

    // a draw that finds both slots full is dropped
    assign store_pending = draw_valid & ~take_draw & (~pending_valid | take_pending);

    always_ff @(posedge clock) begin
        if (reset) begin
            active        <= 1'b0;
            reading       <= 1'b0;
            pixel_index   <= '0;
            pending_valid <= 1'b0;
            tag_valid     <= 1'b0;
            pixel_valid   <= 1'b0;
        end else begin
            tag_valid   <= granted;
            // output stage is tag stage 2
            pixel_valid <= tag_valid & ~(active_flags[0] && read_data == '0);

            if (granted) begin
                pixel_index <= pixel_index + 1'b1;
                if (pixel_index == index_width'(sprite_words - 1)) begin
                    reading <= 1'b0;
                end
            end

            if (take_pending || take_draw) begin
                active      <= 1'b1;
                reading     <= 1'b1;
                pixel_index <= '0;
            end else if (finish) begin
                active <= 1'b0;
            end

            if (store_pending) begin
                pending_valid <= 1'b1;
            end else if (take_pending) begin
                pending_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take_pending) begin
            active_id    <= pending_id;
            active_x     <= pending_x;
            active_y     <= pending_y;
            active_flags <= pending_flags;
        end else if (take_draw) begin
            active_id    <= draw_id;
            active_x     <= draw_x;
            active_y     <= draw_y;
            active_flags <= draw_flags;
        end

        if (store_pending) begin
            pending_id    <= draw_id;
            pending_x     <= draw_x;
            pending_y     <= draw_y;
            pending_flags <= draw_flags;
        end

        tag_column  <= pixel_index[side_width-1:0];
        tag_row     <= pixel_index[2*side_width-1:side_width];
        pixel_x     <= active_x + coord_t'(tag_column); // wraps in 16 bits
        pixel_y     <= active_y + coord_t'(tag_row);
        pixel_color <= read_data;
    end

endmodule

// File: sprite_engine.sv
`timescale 1ns/1ps

module sprite_engine import sprite_pkg::*; #(
    parameter int sprite_count = 8,
    localparam int address_width = $clog2(sprite_count * sprite_words)
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   cs,
    input  logic   sck,
    input  logic   mosi,
    output logic   pixel_valid,
    output coord_t pixel_x,
    output coord_t pixel_y,
    output pixel_t pixel_color,
    output logic   draw_busy
);

    logic                     byte_read;
    logic [7:0]               spi_data;
    logic                     sprite_byte_valid;
    logic [7:0]               sprite_id;
    logic [8:0]               byte_offset;
    logic [7:0]               sprite_data;
    logic                     draw_valid;
    logic [7:0]               draw_id;
    coord_t                   draw_x;
    coord_t                   draw_y;
    logic [7:0]               draw_flags;
    logic                     write_request;
    logic [address_width-1:0] write_address;
    pixel_t                   write_data;
    logic                     read_request;
    logic [address_width-1:0] read_address;
    logic                     read_grant;
    logic                     ram_enable;
    logic                     ram_write;
    logic [address_width-1:0] ram_address;
    pixel_t                   ram_write_data;
    pixel_t                   ram_read_data;

    spi_byte_reader spi_byte_reader_inst (
        .clock     (clock),
        .reset     (reset),
        .cs        (cs),
        .sck       (sck),
        .mosi      (mosi),
        .byte_read (byte_read),
        .data      (spi_data)
    );

    spi_command_parser #(
        .sprite_count (sprite_count)
    ) spi_command_parser_inst (
        .clock             (clock),
        .reset             (reset),
        .cs                (cs),
        .byte_read         (byte_read),
        .data              (spi_data),
        .sprite_byte_valid (sprite_byte_valid),
        .sprite_id         (sprite_id),
        .byte_offset       (byte_offset),
        .sprite_data       (sprite_data),
        .draw_valid        (draw_valid),
        .draw_id           (draw_id),
        .draw_x            (draw_x),
        .draw_y            (draw_y),
        .draw_flags        (draw_flags)
    );

    sprite_loader #(
        .sprite_count (sprite_count)
    ) sprite_loader_inst (
        .clock             (clock),
        .reset             (reset),
        .sprite_byte_valid (sprite_byte_valid),
        .sprite_id         (sprite_id),
        .byte_offset       (byte_offset),
        .sprite_data       (sprite_data),
        .write_request     (write_request),
        .write_address     (write_address),
        .write_data        (write_data)
    );

    sprite_ram_arbiter #(
        .sprite_count (sprite_count)
    ) sprite_ram_arbiter_inst (
        .write_request  (write_request),
        .write_address  (write_address),
        .write_data     (write_data),
        .read_request   (read_request),
        .read_address   (read_address),
        .read_grant     (read_grant),
        .ram_enable     (ram_enable),
        .ram_write      (ram_write),
        .ram_address    (ram_address),
        .ram_write_data (ram_write_data)
    );

    sprite_ram #(
        .sprite_count (sprite_count)
    ) sprite_ram_inst (
        .clock          (clock),
        .ram_enable     (ram_enable),
        .ram_write      (ram_write),
        .ram_address    (ram_address),
        .ram_write_data (ram_write_data),
        .ram_read_data  (ram_read_data)
    );

    sprite_blitter #(
        .sprite_count (sprite_count)
    ) sprite_blitter_inst (
        .clock        (clock),
        .reset        (reset),
        .draw_valid   (draw_valid),
        .draw_id      (draw_id),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .draw_flags   (draw_flags),
        .read_request (read_request),
        .read_address (read_address),
        .read_grant   (read_grant),
        .read_data    (ram_read_data),
        .pixel_valid  (pixel_valid),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .pixel_color  (pixel_color),
        .draw_busy    (draw_busy)
    );

endmodule

// File: sprite_engine_tb.sv
`timescale 1ns/1ps

module sprite_engine_tb import sprite_pkg::*; ();

    localparam int sprite_count = 8;
    localparam int save_bytes = 2 + 2 * sprite_words; // command, id, pixel pairs
    localparam int draw_bytes = 7;
    localparam int total_draws = 7;
    localparam int total_bytes = 4 * save_bytes + total_draws * draw_bytes + 1;
    localparam int watchdog_cycles = (total_bytes * 80 + total_draws * 600) * 2;

    logic   clock;
    logic   reset;
    logic   cs;
    logic   sck;
    logic   mosi;
    logic   pixel_valid;
    coord_t pixel_x;
    coord_t pixel_y;
    pixel_t pixel_color;
    logic   draw_busy;

    pixel_t model_ram [sprite_count * sprite_words]; // what every valid save left behind
    coord_t expected_x [$];
    coord_t expected_y [$];
    pixel_t expected_color [$];
    int     value_errors = 0;
    int     other_errors = 0;

    sprite_engine #(
        .sprite_count (sprite_count)
    ) sprite_engine_inst (
        .clock       (clock),
        .reset       (reset),
        .cs          (cs),
        .sck         (sck),
        .mosi        (mosi),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color),
        .draw_busy   (draw_busy)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // expected pixels of one draw, row-major, positions wrap at 16 bits
    function automatic void build_expected(input logic [7:0] id, input coord_t x,
                                           input coord_t y, input logic [7:0] flags);
        pixel_t color;
        coord_t px;
        coord_t py;
        if (id >= sprite_count) begin
            return; // out-of-range draws show nothing
        end
        for (int row = 0; row < sprite_side; row++) begin
            for (int column = 0; column < sprite_side; column++) begin
                color = model_ram[id * sprite_words + row * sprite_side + column];
                px = x + coord_t'(column);
                py = y + coord_t'(row);
                if (!(flags[0] && color == 16'h0000)) begin
                    expected_x.push_back(px);
                    expected_y.push_back(py);
                    expected_color.push_back(color);
                end
            end
        end
    endfunction

    task automatic compare_coord(input string name, input coord_t actual, input coord_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic compare_color(input string name, input pixel_t actual, input pixel_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clock) begin : compare_pixels
        if (!reset && pixel_valid) begin
            if (expected_x.size() == 0) begin
                other_errors++;
                $display("unexpected pixel at x %h, y %h at %0t", pixel_x, pixel_y, $time);
            end else begin
                compare_coord("pixel_x", pixel_x, expected_x.pop_front());
                compare_coord("pixel_y", pixel_y, expected_y.pop_front());
                compare_color("pixel_color", pixel_color, expected_color.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d clocks, the run did not finish", watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

    task automatic begin_frame();
        cs = 1'b0;
        repeat (2) @(negedge clock);
    endtask

    task automatic end_frame();
        sck = 1'b0;
        repeat (4) @(negedge clock);
        cs = 1'b1;
        repeat (4) @(negedge clock);
    endtask

    task automatic send_byte(input logic [7:0] value);
        for (int b = 7; b >= 0; b--) begin // msb first
            mosi = value[b];
            sck  = 1'b0;
            repeat (4) @(negedge clock);
            sck  = 1'b1;
            repeat (4) @(negedge clock);
        end
    endtask

    task automatic send_draw_bytes(input logic [7:0] id, input coord_t x, input coord_t y,
                                   input logic [7:0] flags);
        send_byte(command_draw_sprite);
        send_byte(id);
        send_byte(x[15:8]);
        send_byte(x[7:0]);
        send_byte(y[15:8]);
        send_byte(y[7:0]);
        send_byte(flags);
    endtask

    // random pixels, about a quarter of them zero when asked for
    task automatic save_sprite(input logic [7:0] id, input bit with_zeros);
        pixel_t pixels [sprite_words];
        for (int i = 0; i < sprite_words; i++) begin
            pixels[i] = pixel_t'($urandom);
            if (with_zeros && $urandom_range(3) == 0) begin
                pixels[i] = 16'h0000;
            end
        end
        begin_frame();
        send_byte(command_save_sprite);
        send_byte(id);
        for (int i = 0; i < sprite_words; i++) begin
            send_byte(pixels[i][15:8]);
            send_byte(pixels[i][7:0]);
        end
        end_frame();
        if (id < sprite_count) begin
            for (int i = 0; i < sprite_words; i++) begin
                model_ram[id * sprite_words + i] = pixels[i];
            end
        end
    endtask

    task automatic wait_draw_done();
        while (draw_busy) begin
            @(negedge clock);
        end
        if (expected_x.size() != 0) begin
            other_errors++;
            $display("%0d expected pixels never appeared at %0t", expected_x.size(), $time);
            expected_x.delete();
            expected_y.delete();
            expected_color.delete();
        end
    endtask

    task automatic draw_sprite(input logic [7:0] id, input coord_t x, input coord_t y,
                               input logic [7:0] flags);
        build_expected(id, x, y, flags);
        begin_frame();
        send_draw_bytes(id, x, y, flags);
        end_frame();
        wait_draw_done();
    endtask

    initial begin
        void'($urandom(65));
        reset = 1'b1;
        cs    = 1'b1;
        sck   = 1'b0;
        mosi  = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        repeat (2) @(negedge clock);

        save_sprite(8'd3, 1'b0);
        draw_sprite(8'd3, 16'd100, 16'd50, 8'h00);

        save_sprite(8'd5, 1'b1);
        draw_sprite(8'd5, 16'd200, 16'd10, 8'h01); // transparent

        save_sprite(8'd3, 1'b0); // replaces the first id 3 sprite
        draw_sprite(8'd3, 16'd7, 16'd300, 8'h00);

        // unknown command byte followed by a draw in the same frame
        build_expected(8'd5, 16'd20, 16'd30, 8'h00);
        begin_frame();
        send_byte(8'h7e);
        send_draw_bytes(8'd5, 16'd20, 16'd30, 8'h00);
        end_frame();
        wait_draw_done();

        save_sprite(8'd9, 1'b0); // id beyond sprite_count
        draw_sprite(8'd9, 16'd40, 16'd40, 8'h00);
        draw_sprite(8'd3, 16'd1, 16'd2, 8'h00);

        draw_sprite(8'd3, 16'hfff8, 16'hfff8, 8'h00); // wraps past 0xffff

        repeat (4) @(negedge clock);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: project.f
sprite_pkg.sv
spi_byte_reader.sv
spi_command_parser.sv
sprite_loader.sv
sprite_ram_arbiter.sv
sprite_ram.sv
sprite_blitter.sv
sprite_engine.sv
sprite_engine_tb.sv

// File: Bender.yml
package:
  name: sprite_engine

sources:
  - sprite_pkg.sv
  - spi_byte_reader.sv
  - spi_command_parser.sv
  - sprite_loader.sv
  - sprite_ram_arbiter.sv
  - sprite_ram.sv
  - sprite_blitter.sv
  - sprite_engine.sv
  - target: simulation
    files:
      - sprite_engine_tb.sv
